// File: bench/data_mem_tb.sv
`default_nettype none
`timescale 1ns/1ps

module data_mem_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int N_REC       = 32;     // records in the trace
    localparam int REC_W       = 84;     // 21 hex digits per record
    localparam int WATCHDOG    = N_REC * 4 + 50;
    localparam int DRAIN_LIMIT = mem_pkg::QUEUE_DEPTH * 3 + 4;  // full queue plus credit lag

    logic                clk_i;
    logic                rst_n_i;
    logic                req_valid_i;
    logic                req_we_i;
    mem_pkg::mem_size_t  req_size_i;
    mem_pkg::byte_addr_t req_addr_i;
    mem_pkg::word_t      req_wdata_i;
    logic                credit_o;
    logic                resp_valid_o;
    mem_pkg::word_t      resp_data_o;

    logic [REC_W-1:0] trace [N_REC];
    logic [REC_W-1:0] rec;
    mem_pkg::word_t   exp_q [$];        // load results still owed, in order
    mem_pkg::word_t   exp_word;
    mem_pkg::credit_cnt_t credits;

    int sent;           // requests issued
    int returned;       // credit pulses seen
    int loads_sent;
    int loads_done;
    int errors;
    int checks;
    int tests_run;
    int base;
    int idx;
    int n_valid;
    int wait_cycles;
    bit burst_hit;      // credit count reached zero at least once

    data_mem uut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_we_i     (req_we_i),
        .req_size_i   (req_size_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .credit_o     (credit_o),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_word(input string name, input mem_pkg::word_t got,
                              input mem_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_credits(input string name, input mem_pkg::credit_cnt_t got,
                                 input mem_pkg::credit_cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int first_err);
        tests_run++;
        $display("test %-16s %s (%0d errors)", name,
                 (errors == first_err) ? "ok" : "FAILED", errors - first_err);
    endtask

    // --------------------
    // response side
    // --------------------
    // sampled mid cycle while the outputs are settled
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (credit_o === 1'b1) returned++;
            if (resp_valid_o === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("load response arrived with no load pending");
                end else begin
                    exp_word = exp_q.pop_front();
                    check_word($sformatf("resp_data_o (load %0d)", loads_done),
                               resp_data_o, exp_word);
                    loads_done++;
                end
            end
        end
    end

    // watchdog
    initial begin
        #(CLK_PERIOD * WATCHDOG);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG);
        $display("Simulation failed");
        $finish;
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin
        void'($urandom(32'h65d1_10ca));
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_we_i    = 1'b0;
        req_size_i  = '0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        $readmemh("bench/data_mem_trace.txt", trace);
        n_valid = N_REC;
        if ($isunknown(trace[N_REC-1]) || trace[N_REC-1] == '0) begin
            errors++;
            n_valid = 0;        // nothing to drive
            $display("trace file is missing or has fewer than %0d records", N_REC);
        end

        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // quiet after reset
        base = errors;
        repeat (6) begin
            @(negedge clk_i);
            check_flag("resp_valid_o", resp_valid_o, 1'b0);
            check_flag("credit_o", credit_o, 1'b0);
        end
        report_test("idle_after_reset", base);

        // one trace request per edge while a credit is held
        base = errors;
        while (idx < n_valid) begin
            @(posedge clk_i);
            credits = mem_pkg::credit_cnt_t'(mem_pkg::QUEUE_DEPTH - sent + returned);
            if (credits == 0) burst_hit = 1'b1;
            if (credits != 0 && ($urandom % 8) != 0) begin
                rec          = trace[idx];
                req_valid_i <= 1'b1;
                req_we_i    <= rec[80];       // store flag
                req_size_i  <= rec[78:76];
                req_addr_i  <= rec[75:64];
                req_wdata_i <= rec[63:32];
                if (!rec[80]) begin
                    exp_q.push_back(rec[31:0]);
                    loads_sent++;
                end
                sent++;
                idx++;
            end else begin
                req_valid_i <= 1'b0;        // out of credits or random gap
            end
        end
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        while (loads_done != loads_sent) @(negedge clk_i);
        report_test("trace_loads", base);

        // every credit back once the queue drains
        base = errors;
        wait_cycles = 0;
        while (returned != sent && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clk_i);
            wait_cycles++;
        end
        repeat (3) @(negedge clk_i);    // a stray pulse would land here
        credits = mem_pkg::credit_cnt_t'(mem_pkg::QUEUE_DEPTH - sent + returned);
        check_credits("credit count", credits, mem_pkg::credit_cnt_t'(mem_pkg::QUEUE_DEPTH));
        if (!burst_hit && n_valid != 0) begin
            errors++;
            $display("request burst never used up all credits");
        end
        report_test("credit_return", base);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/data_mem_trace.txt
// one request per line: store(1) size(1) addr(3) wdata(8) expected(8), hex digits
// size is funct3: 0 lb, 1 lh, 2 lw, 4 lbu, 5 lhu; expected is 0 for stores
120001122334400000000 // sw 000
120048091a2f300000000 // sw 004
12008deadbeef00000000 // sw 008
1200c7f00ff8000000000 // sw 00c
12ffccafef00d00000000 // sw ffc
020000000000011223344 // lw 000
02004000000008091a2f3 // lw 004
02ffc00000000cafef00d // lw ffc
0000400000000fffffff3 // lb 004
0400400000000000000f3 // lbu 004
0000500000000ffffffa2 // lb 005
0000600000000ffffff91 // lb 006
040070000000000000080 // lbu 007
0000700000000ffffff80 // lb 007
0100400000000ffffa2f3 // lh 004
05004000000000000a2f3 // lhu 004
0100600000000ffff8091 // lh 006
050060000000000008091 // lhu 006
0000c00000000ffffff80 // lb 00c
0000f000000000000007f // lb 00f
0100e0000000000007f00 // lh 00e
10001000000aa00000000 // sb 001
1100a1234567800000000 // sh 00a
1000b000000c300000000 // sb 00b
1100c0000aaaa00000000 // sh 00c
02000000000001122aa44 // lw 000
0200800000000c378beef // lw 008
0400b00000000000000c3 // lbu 00b
0200c000000007f00aaaa // lw 00c
0100a00000000ffffc378 // lh 00a
0500c000000000000aaaa // lhu 00c
02004000000008091a2f3 // lw 004

// File: design/data_mem.sv
`default_nettype none
`timescale 1ns/1ps

// data memory subsystem: credit queue -> load/store controller -> block ram
module data_mem (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // request, only while a credit is held
    input  logic                req_valid_i,
    input  logic                req_we_i,
    input  mem_pkg::mem_size_t  req_size_i,
    input  mem_pkg::byte_addr_t req_addr_i,
    input  mem_pkg::word_t      req_wdata_i,
    output logic                credit_o,       // one pulse per popped request
    // load results, no back-pressure
    output logic                resp_valid_o,
    output mem_pkg::word_t      resp_data_o
);

    // queue head
    logic                q_valid;
    logic                q_we;
    mem_pkg::mem_size_t  q_size;
    mem_pkg::byte_addr_t q_addr;
    mem_pkg::word_t      q_wdata;
    logic                q_pop;

    // ram port
    mem_pkg::word_addr_t mem_addr;
    mem_pkg::word_t      mem_wdata;
    mem_pkg::word_t      mem_rdata;
    logic                mem_wr_n;
    logic                mem_rd_n;

    req_queue u_queue (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .push_i   (req_valid_i),
        .we_i     (req_we_i),
        .size_i   (req_size_i),
        .addr_i   (req_addr_i),
        .wdata_i  (req_wdata_i),
        .pop_i    (q_pop),
        .valid_o  (q_valid),
        .we_o     (q_we),
        .size_o   (q_size),
        .addr_o   (q_addr),
        .wdata_o  (q_wdata),
        .credit_o (credit_o)
    );

    mem_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .q_valid_i    (q_valid),
        .q_we_i       (q_we),
        .q_size_i     (q_size),
        .q_addr_i     (q_addr),
        .q_wdata_i    (q_wdata),
        .q_pop_o      (q_pop),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_wr_n_o   (mem_wr_n),
        .mem_rd_n_o   (mem_rd_n),
        .mem_rdata_i  (mem_rdata),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o)
    );

    memory u_ram (
        .clk_i  (clk_i),
        .data_i (mem_wdata),
        .addr_i (mem_addr),
        .wr_i   (mem_wr_n),   // active low
        .rd_i   (mem_rd_n),   // active low
        .data_o (mem_rdata)
    );

endmodule

`default_nettype wire

// File: design/mem_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

// load/store sequencer in front of the ram
// loads: lane select + sign/zero extend
// sub-word stores: read, merge lane, write back
module mem_ctrl (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // queue head
    input  logic                q_valid_i,
    input  logic                q_we_i,
    input  mem_pkg::mem_size_t  q_size_i,
    input  mem_pkg::byte_addr_t q_addr_i,
    input  mem_pkg::word_t      q_wdata_i,
    output logic                q_pop_o,
    // ram side, strobes active low
    output mem_pkg::word_addr_t mem_addr_o,
    output mem_pkg::word_t      mem_wdata_o,
    output logic                mem_wr_n_o,
    output logic                mem_rd_n_o,
    input  mem_pkg::word_t      mem_rdata_i,
    // load results, in request order
    output logic                resp_valid_o,
    output mem_pkg::word_t      resp_data_o
);

    typedef enum logic [1:0] {
        ST_IDLE,       // waiting on the queue
        ST_LOAD_RD,    // ram read in flight, loads and rmw stores
        ST_LOAD_RET,   // load result on the response port
        ST_MERGE_WR    // merged word being written back
    } ctrl_state_t;

    ctrl_state_t state;

    // request held while it executes
    logic                       we_r;
    mem_pkg::mem_size_t         size_r;
    logic [mem_pkg::LANE_W-1:0] lane_r;
    mem_pkg::word_t             wdata_r;

    logic word_store;   // store that skips the read

    // --------------------
    // datapath helpers
    // --------------------
    // pick the addressed lane and extend by size code
    function automatic mem_pkg::word_t load_extend(
        input mem_pkg::word_t             w,
        input logic [mem_pkg::LANE_W-1:0] lane,
        input mem_pkg::mem_size_t         sz
    );
        logic [7:0]  b;
        logic [15:0] h;
        b = w[{lane, 3'b000} +: 8];
        h = lane[1] ? w[31:16] : w[15:0];   // lane[0] ignored, aligned only
        case (sz)
            mem_pkg::MEM_LB:  return {{24{b[7]}}, b};
            mem_pkg::MEM_LBU: return {24'h0, b};
            mem_pkg::MEM_LH:  return {{16{h[15]}}, h};
            mem_pkg::MEM_LHU: return {16'h0, h};
            mem_pkg::MEM_LW:  return w;
            default:          return w;     // unused codes read as word
        endcase
    endfunction

    // drop the low bits of the store data into one lane of the old word
    function automatic mem_pkg::word_t merge_lane(
        input mem_pkg::word_t             old_w,
        input mem_pkg::word_t             wd,
        input logic [mem_pkg::LANE_W-1:0] lane,
        input mem_pkg::mem_size_t         sz
    );
        mem_pkg::word_t r;
        r = old_w;
        if (sz == mem_pkg::MEM_LB) begin
            r[{lane, 3'b000} +: 8] = wd[7:0];        // sb
        end else begin
            r[{lane[1], 4'b0000} +: 16] = wd[15:0];  // sh
        end
        return r;
    endfunction

    assign word_store = q_we_i && (q_size_i == mem_pkg::MEM_LW);

    // take the head only between requests
    assign q_pop_o = (state == ST_IDLE) && q_valid_i;

    // --------------------
    // control
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state        <= ST_IDLE;
            mem_wr_n_o   <= 1'b1;
            mem_rd_n_o   <= 1'b1;
            resp_valid_o <= 1'b0;
        end else begin
            mem_wr_n_o   <= 1'b1;   // strobes are single cycle
            mem_rd_n_o   <= 1'b1;
            resp_valid_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (q_valid_i) begin
                        if (word_store) begin
                            mem_wr_n_o <= 1'b0;   // one cycle, stay idle
                        end else begin
                            mem_rd_n_o <= 1'b0;   // load or rmw read
                            state      <= ST_LOAD_RD;
                        end
                    end
                end
                ST_LOAD_RD: begin
                    if (we_r) begin
                        mem_wr_n_o <= 1'b0;       // write back merged word
                        state      <= ST_MERGE_WR;
                    end else begin
                        resp_valid_o <= 1'b1;
                        state        <= ST_LOAD_RET;
                    end
                end
                ST_LOAD_RET: state <= ST_IDLE;
                ST_MERGE_WR: state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // --------------------
    // payload
    // --------------------
    always_ff @(posedge clk_i) begin
        if (q_pop_o) begin
            we_r        <= q_we_i;
            size_r      <= q_size_i;
            lane_r      <= q_addr_i[mem_pkg::LANE_W-1:0];
            wdata_r     <= q_wdata_i;
            mem_addr_o  <= q_addr_i[mem_pkg::BYTE_ADDR_W-1:mem_pkg::LANE_W];
            mem_wdata_o <= q_wdata_i;   // used as is by word stores
        end
        if (state == ST_LOAD_RD) begin
            if (we_r) begin
                mem_wdata_o <= merge_lane(mem_rdata_i, wdata_r, lane_r, size_r);
            end else begin
                resp_data_o <= load_extend(mem_rdata_i, lane_r, size_r);
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none

// shared widths, access codes and queue sizing for the data memory
package mem_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int WORD_W      = 32;
    localparam int BYTE_ADDR_W = 12;                    // 4 KB byte space
    localparam int LANE_W      = 2;                     // byte offset inside a word
    localparam int WORD_ADDR_W = BYTE_ADDR_W - LANE_W;  // 1K words
    localparam int MEM_WORDS   = 1 << WORD_ADDR_W;
    localparam int SIZE_W      = 3;                     // funct3 field
    localparam int CREDIT_W    = 3;                     // holds 0..QUEUE_DEPTH

    // request queue, depth is a power of two so pointers wrap on their own
    localparam int QUEUE_DEPTH = 4;                     // also the credits held after reset
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [SIZE_W-1:0]      mem_size_t;
    typedef logic [CREDIT_W-1:0]    credit_cnt_t;

    // --------------------
    // access size codes
    // --------------------
    // same encoding as the load/store funct3 field,
    // stores use only the three signed codes (sb, sh, sw)
    localparam mem_size_t MEM_LB  = 3'b000;   // byte, sign extended
    localparam mem_size_t MEM_LH  = 3'b001;   // half, sign extended
    localparam mem_size_t MEM_LW  = 3'b010;   // full word
    localparam mem_size_t MEM_LBU = 3'b100;   // byte, zero extended
    localparam mem_size_t MEM_LHU = 3'b101;   // half, zero extended

endpackage

`default_nettype wire

// File: design/memory.sv
`default_nettype none
`timescale 1ns/1ps

// 1K x 32 block ram, both ports act on the falling edge
module memory (
    input  logic                clk_i,     // rising edge belongs to the controller
    input  mem_pkg::word_t      data_i,    // write data
    input  mem_pkg::word_addr_t addr_i,    // word index
    input  logic                wr_i,      // write enable, active low
    input  logic                rd_i,      // read enable, active low
    output mem_pkg::word_t      data_o     // read data, held between reads
);

    // storage
    mem_pkg::word_t mem [mem_pkg::MEM_WORDS];

    // sim only, ram powers up as zero
    initial begin
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // --------------------
    // write port
    // --------------------
    always_ff @(negedge clk_i) begin
        if (!wr_i) begin
            mem[addr_i] <= data_i;   // lands mid cycle
        end
    end

    // --------------------
    // read port
    // --------------------
    // output register only moves on a read, so the last word stays
    // visible to the controller until the next read strobe
    always_ff @(negedge clk_i) begin
        if (!rd_i) begin
            data_o <= mem[addr_i];   // stable by the next rising edge
        end
    end

endmodule

`default_nettype wire

// File: design/req_queue.sv
`default_nettype none
`timescale 1ns/1ps

// request fifo sitting behind the credit interface
module req_queue (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // enqueue side, one slot guaranteed by the credit held
    input  logic                push_i,
    input  logic                we_i,
    input  mem_pkg::mem_size_t  size_i,
    input  mem_pkg::byte_addr_t addr_i,
    input  mem_pkg::word_t      wdata_i,
    // head of queue
    input  logic                pop_i,
    output logic                valid_o,
    output logic                we_o,
    output mem_pkg::mem_size_t  size_o,
    output mem_pkg::byte_addr_t addr_o,
    output mem_pkg::word_t      wdata_o,
    // one pulse per freed slot
    output logic                credit_o
);

    // entry storage
    logic                we_q    [mem_pkg::QUEUE_DEPTH];
    mem_pkg::mem_size_t  size_q  [mem_pkg::QUEUE_DEPTH];
    mem_pkg::byte_addr_t addr_q  [mem_pkg::QUEUE_DEPTH];
    mem_pkg::word_t      wdata_q [mem_pkg::QUEUE_DEPTH];

    logic [mem_pkg::QPTR_W-1:0] wr_ptr;
    logic [mem_pkg::QPTR_W-1:0] rd_ptr;
    mem_pkg::credit_cnt_t       count;   // occupancy

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i;                    // slot freed, hand the credit back
            if (push_i) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (pop_i)  rd_ptr <= rd_ptr + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // both or neither
            endcase
        end
    end

    // payload, written at the tail
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            we_q[wr_ptr]    <= we_i;
            size_q[wr_ptr]  <= size_i;
            addr_q[wr_ptr]  <= addr_i;
            wdata_q[wr_ptr] <= wdata_i;
        end
    end

    // head fields straight off the read pointer
    assign valid_o = (count != '0);
    assign we_o    = we_q[rd_ptr];
    assign size_o  = size_q[rd_ptr];
    assign addr_o  = addr_q[rd_ptr];
    assign wdata_o = wdata_q[rd_ptr];

endmodule

`default_nettype wire

// File: list.f
design/mem_pkg.sv
design/memory.sv
design/req_queue.sv
design/mem_ctrl.sv
design/data_mem.sv
bench/data_mem_tb.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, and look for the pass line
verilator --binary --timing -Wno-fatal -f list.f --top-module data_mem_tb -o data_mem_sim \
    && out=$(./obj_dir/data_mem_sim) || { echo "build or run failed"; exit 1; }
echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1
